/* Bender.yml */
package:
  name: mdu

sources:
  - files:
      - source/mduPkg.sv
      - source/mulPipeline.sv
      - source/divStepCounter.sv
      - source/divDatapath.sv
      - source/mduSequencer.sv
      - source/mduTop.sv
  - target: simulation
    files:
      - sim/mduProps_props.sv
      - sim/mduTb.sv

/* list.f */
source/mduPkg.sv
source/mulPipeline.sv
source/divStepCounter.sv
source/divDatapath.sv
source/mduSequencer.sv
source/mduTop.sv
sim/mduProps_props.sv
sim/mduTb.sv

/* sim/mduProps_props.sv */
`timescale 1ns/1ps

module mduProps (
    input logic              clk,
    input logic              rst,
    input mduPkg::wbPortT    wb,
    input mduPkg::robFinishT robFinish,
    input logic              issueReady,
    input logic              divDone,
    input logic              hiBeat
);

    int failCount = 0;

    // every write-back beat also marks its instruction finished.
    finishWithWrite: assert property (@(posedge clk) disable iff (rst)
        wb.wen == robFinish.setFinish)
        else begin
            $error("write enable and finish strobe disagree");
            failCount++;
        end

    hiFollowedByLo: assert property (@(posedge clk) disable iff (rst)
        hiBeat |=> wb.wen)
        else begin
            $error("HI beat not followed by a write beat");
            failCount++;
        end

    // a held division result keeps the issue side closed.
    noIssueWhileHeld: assert property (@(posedge clk) disable iff (rst)
        divDone |-> !issueReady)
        else begin
            $error("issueReady high while a division result is held");
            failCount++;
        end

endmodule

bind mduSequencer mduProps i_mduProps (
    .clk        (clk),
    .rst        (rst),
    .wb         (wb),
    .robFinish  (robFinish),
    .issueReady (issueReady),
    .divDone    (divDone),
    .hiBeat     ((state == mulHi) || (state == divHi))
);

/* sim/mduTb.sv */
`timescale 1ns/1ps

module mduTb;

    // about 50 divisions at roughly 36 cycles each plus the multiplies use under
    // a third of this limit.
    localparam int TimeoutCycles = 6000;

    logic              clk = 1'b0;
    logic              rst;
    mduPkg::mduIssueT  issue;
    logic              issueReady;
    mduPkg::wbPortT    wb;
    mduPkg::robFinishT robFinish;

    int         cycleCount   = 0;
    int         errorCount   = 0;
    int         testErrors   = 0;
    int         testsOk      = 0;
    int         testsBad     = 0;
    int         opIndex      = 0;
    int         pendingCount = 0;
    int         beatCount    = 0;
    int         assertFails  = 0;
    int         lastCycle    = -10;
    logic [5:0] lastRd       = '0;
    string      curTest      = "startup";

    // expected results, indexed by destination register.
    logic        pending   [64] = '{default: 1'b0};
    logic [31:0] expData   [64];
    logic [4:0]  expRob    [64];
    logic        isLo      [64];
    logic [5:0]  pairRd    [64];
    int          beatCycle [64];

    mduTop i_mduTop (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .issueReady (issueReady),
        .wb         (wb),
        .robFinish  (robFinish)
    );

    always #10 clk = ~clk;

    // ####################
    // model and checks
    // ####################

    // returns {HI, LO}; the divide rules come from the language's own signed arithmetic.
    function automatic logic [63:0] modelResult(input mduPkg::mduOpT op,
                                                input logic [31:0] a, input logic [31:0] b);
        int          sa;
        int          sb;
        longint      sProd;
        logic [63:0] result;
        sa = a;
        sb = b;
        case (op)
            mduPkg::opMult: begin
                sProd  = longint'(sa) * longint'(sb);
                result = sProd;
            end
            mduPkg::opMultu: result = {32'd0, a} * {32'd0, b};
            mduPkg::opDiv:   result = {32'(sa % sb), 32'(sa / sb)};
            default:         result = {a % b, a / b};
        endcase
        return result;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("ERROR %s: %s expected 0x%h, actual 0x%h", curTest, what, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkCycle(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("ERROR %s: %s expected %0d, actual %0d", curTest, what, expected, actual);
            errorCount++;
        end
    endtask

    task automatic recordBeat(input logic [5:0] rd, input logic [31:0] data,
                              input logic [4:0] robId, input int cycle);
        assert (pending[rd]) else begin
            $display("%s: write-back beat to rd %0d with no operation waiting for it",
                     curTest, rd);
            errorCount++;
        end
        if (pending[rd]) begin
            checkValue($sformatf("rd %0d data", rd), expData[rd], data);
            checkValue($sformatf("rd %0d rob id", rd), 32'(expRob[rd]), 32'(robId));
            if (isLo[rd]) begin
                assert (lastRd == pairRd[rd] && lastCycle == cycle - 1) else begin
                    $display("%s: LO beat on rd %0d does not directly follow its HI beat",
                             curTest, rd);
                    errorCount++;
                end
            end
            pending[rd]   = 1'b0;
            beatCycle[rd] = cycle;
            pendingCount--;
        end
        beatCount++;
        lastRd    = rd;
        lastCycle = cycle;
    endtask

    // the beat of the ending cycle is taken before the cycle number moves on.
    always @(posedge clk) begin
        if (!rst && wb.wen) begin
            recordBeat(wb.rd, wb.wdata, robFinish.id, cycleCount);
        end
        cycleCount = cycleCount + 1;
    end

    initial begin
        wait (cycleCount >= TimeoutCycles);
        $display("timeout: run stopped after %0d cycles with %0d beats outstanding",
                 cycleCount, pendingCount);
        $display("Test failed");
        $finish;
    end

    // ####################
    // stimulus
    // ####################

    // called on a falling edge; returns one falling edge after the accepting cycle.
    task automatic sendOp(input mduPkg::mduOpT op, input logic [31:0] a, input logic [31:0] b,
                          output int acceptCycle, output logic [5:0] hiRd,
                          output logic [5:0] loRd);
        logic [63:0] expected;
        hiRd = 6'(2 * (opIndex % 16));
        loRd = hiRd + 6'd1;
        opIndex++;
        while (pending[hiRd] || pending[loRd]) begin
            @(negedge clk);
        end
        expected      = modelResult(op, a, b);
        expData[hiRd] = expected[63:32];
        expData[loRd] = expected[31:0];
        expRob[hiRd]  = hiRd[4:0];
        expRob[loRd]  = loRd[4:0];
        isLo[hiRd]    = 1'b0;
        isLo[loRd]    = 1'b1;
        pairRd[loRd]  = hiRd;
        pending[hiRd] = 1'b1;
        pending[loRd] = 1'b1;
        pendingCount += 2;
        issue.valid   = 1'b1;
        issue.op      = op;
        issue.rdHi    = hiRd;
        issue.rdLo    = loRd;
        issue.robIdHi = hiRd[4:0];
        issue.robIdLo = loRd[4:0];
        issue.rs0     = a;
        issue.rs1     = b;
        while (!issueReady) begin
            @(negedge clk);
        end
        acceptCycle = cycleCount;
        @(negedge clk);
        issue.valid = 1'b0;
    endtask

    task automatic waitDrain();
        while (pendingCount != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic startTest(input string name);
        curTest    = name;
        testErrors = errorCount;
    endtask

    task automatic reportTest();
        // failures of the bound sequencer assertions count against the running test.
        errorCount += i_mduTop.i_mduSequencer.i_mduProps.failCount - assertFails;
        assertFails = i_mduTop.i_mduSequencer.i_mduProps.failCount;
        if (errorCount == testErrors) begin
            testsOk++;
            $display("%s: ok", curTest);
        end else begin
            testsBad++;
            $display("%s: %0d errors", curTest, errorCount - testErrors);
        end
    endtask

    task automatic mulCase(input mduPkg::mduOpT op, input logic [31:0] a, input logic [31:0] b);
        int         acceptCycle;
        logic [5:0] hiRd;
        logic [5:0] loRd;
        sendOp(op, a, b, acceptCycle, hiRd, loRd);
        waitDrain();
        checkCycle("HI beat cycle", acceptCycle + 4, beatCycle[hiRd]);
        checkCycle("LO beat cycle", acceptCycle + 5, beatCycle[loRd]);
    endtask

    task automatic divCase(input mduPkg::mduOpT op, input logic [31:0] a, input logic [31:0] b);
        int         acceptCycle;
        logic [5:0] hiRd;
        logic [5:0] loRd;
        sendOp(op, a, b, acceptCycle, hiRd, loRd);
        while (pending[loRd]) begin
            checkValue("issueReady during divide", 1'b0, issueReady);
            @(negedge clk);
        end
        checkValue("issueReady after LO beat", 1'b1, issueReady);
        assert (beatCycle[hiRd] - acceptCycle >= 34) else begin
            $display("%s: divide result came %0d cycles after acceptance, expected at least 34",
                     curTest, beatCycle[hiRd] - acceptCycle);
            errorCount++;
        end
    endtask

    // ####################
    // tests
    // ####################

    task automatic resetState();
        startTest("reset state");
        checkValue("wb.wen", 1'b0, wb.wen);
        checkValue("setFinish", 1'b0, robFinish.setFinish);
        checkValue("issueReady", 1'b1, issueReady);
        reportTest();
    endtask

    task automatic multiplyValues();
        startTest("multiply values");
        mulCase(mduPkg::opMult, 32'd7, -32'sd3);
        mulCase(mduPkg::opMult, 32'h7fff_ffff, 32'h7fff_ffff);
        mulCase(mduPkg::opMultu, 32'hffff_ffff, 32'hffff_ffff);
        mulCase(mduPkg::opMult, 32'd0, 32'h1234_5678);
        mulCase(mduPkg::opMult, 32'h8000_0000, 32'h8000_0000);
        mulCase(mduPkg::opMultu, 32'h8000_0000, 32'd2);
        reportTest();
    endtask

    task automatic backToBackMultiplies();
        int         acceptCycle [4];
        logic [5:0] hiRd        [4];
        logic [5:0] loRd        [4];
        startTest("back-to-back multiplies");
        for (int i = 0; i < 4; i++) begin
            sendOp(mduPkg::mduOpT'(i[0] ? mduPkg::opMultu : mduPkg::opMult), $urandom, $urandom,
                   acceptCycle[i], hiRd[i], loRd[i]);
            checkValue("issueReady after accept", 1'b0, issueReady);
            if (i > 0) begin
                checkCycle("accept cycle", acceptCycle[i-1] + 2, acceptCycle[i]);
            end
        end
        waitDrain();
        for (int i = 0; i < 4; i++) begin
            checkCycle("HI beat cycle", acceptCycle[i] + 4, beatCycle[hiRd[i]]);
            if (i > 0) begin
                // results leave in issue order, one beat pair after the other.
                checkCycle("HI beat after previous LO", beatCycle[loRd[i-1]] + 1,
                           beatCycle[hiRd[i]]);
            end
        end
        reportTest();
    endtask

    task automatic divideValues();
        startTest("divide values");
        divCase(mduPkg::opDiv, -32'sd7, 32'd2);
        divCase(mduPkg::opDiv, 32'd7, -32'sd2);
        divCase(mduPkg::opDiv, -32'sd7, -32'sd2);
        divCase(mduPkg::opDiv, 32'd5, -32'sd1);
        divCase(mduPkg::opDiv, 32'h8000_0000, 32'd3);
        divCase(mduPkg::opDivu, 32'hffff_ffff, 32'd3);
        divCase(mduPkg::opDivu, 32'd100, 32'd7);
        reportTest();
    endtask

    task automatic randomMix();
        int            beatsBefore;
        int            acceptCycle;
        logic [5:0]    hiRd;
        logic [5:0]    loRd;
        mduPkg::mduOpT op;
        logic [31:0]   a;
        logic [31:0]   b;
        startTest("random mix");
        beatsBefore = beatCount;
        for (int i = 0; i < 40; i++) begin
            op = mduPkg::mduOpT'($urandom_range(3, 0));
            a  = $urandom;
            b  = $urandom >> $urandom_range(31, 0);
            if (op == mduPkg::opDiv || op == mduPkg::opDivu) begin
                if (b == 32'd0) begin
                    b = 32'd1;
                end
                // the most negative value over minus one has no 32-bit quotient.
                if (op == mduPkg::opDiv && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                    b = 32'd1;
                end
            end
            sendOp(op, a, b, acceptCycle, hiRd, loRd);
            repeat ($urandom_range(2, 0)) @(negedge clk);
        end
        waitDrain();
        checkCycle("beat count", 80, beatCount - beatsBefore);
        reportTest();
    endtask

    initial begin
        void'($urandom(49));
        rst   = 1'b1;
        issue = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        resetState();
        multiplyValues();
        backToBackMultiplies();
        divideValues();
        randomMix();
        $display("tests ok: %0d, tests with errors: %0d, errors: %0d",
                 testsOk, testsBad, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* source/divDatapath.sv */
`timescale 1ns/1ps

module divDatapath (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         divStart,
    input  logic [mduPkg::DataWidth-1:0] dividend,
    input  logic [mduPkg::DataWidth-1:0] divisor,
    input  mduPkg::mduTagT               tagIn,
    input  logic                         lastStep,
    input  logic                         divTaken,
    output logic                         stepEnable,
    output logic                         load,
    output logic                         divDone,
    output mduPkg::mduTagT               divOut,
    output logic [mduPkg::DataWidth-1:0] quotient,
    output logic [mduPkg::DataWidth-1:0] remainder
);
    logic                         busy;
    mduPkg::mduTagT               tagReg;
    logic [mduPkg::DataWidth-1:0] remReg;
    logic [mduPkg::DataWidth-1:0] quoReg;
    logic [mduPkg::DataWidth-1:0] divisorReg;
    logic                         negQuo;
    logic                         negRem;
    logic [mduPkg::DataWidth-1:0] dividendMag;
    logic [mduPkg::DataWidth-1:0] divisorMag;
    logic [mduPkg::DataWidth:0]   shifted;
    logic [mduPkg::DataWidth+1:0] diff;

    assign dividendMag = (tagIn.signedOp && dividend[mduPkg::DataWidth-1]) ? -dividend : dividend;
    assign divisorMag  = (tagIn.signedOp && divisor[mduPkg::DataWidth-1]) ? -divisor : divisor;

    // bring down the next dividend bit and try the subtraction.
    assign shifted = {remReg, quoReg[mduPkg::DataWidth-1]};
    assign diff    = {1'b0, shifted} - {2'b00, divisorReg};

    assign load       = divStart;
    assign stepEnable = busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            divDone <= 1'b0;
            tagReg  <= '0;
        end else if (divStart) begin
            busy   <= 1'b1;
            tagReg <= tagIn;
        end else if (busy && lastStep) begin
            busy    <= 1'b0;
            divDone <= 1'b1;
        end else if (divTaken) begin
            divDone <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (divStart) begin
            remReg     <= '0;
            quoReg     <= dividendMag;
            divisorReg <= divisorMag;
            negQuo     <= tagIn.signedOp && (dividend[mduPkg::DataWidth-1] ^
                                             divisor[mduPkg::DataWidth-1]);
            negRem     <= tagIn.signedOp && dividend[mduPkg::DataWidth-1];
        end else if (busy) begin
            if (!diff[mduPkg::DataWidth+1]) begin
                remReg <= diff[mduPkg::DataWidth-1:0];
                quoReg <= {quoReg[mduPkg::DataWidth-2:0], 1'b1};
            end else begin
                remReg <= shifted[mduPkg::DataWidth-1:0];
                quoReg <= {quoReg[mduPkg::DataWidth-2:0], 1'b0};
            end
        end
    end

    // the remainder follows the dividend sign, so the quotient truncates toward zero.
    assign quotient  = negQuo ? -quoReg : quoReg;
    assign remainder = negRem ? -remReg : remReg;
    assign divOut    = tagReg;

endmodule

/* source/divStepCounter.sv */
`timescale 1ns/1ps

module divStepCounter (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  logic stepEnable,
    output logic lastStep
);
    mduPkg::divCountT count;

    // counts down the remaining iterations and parks at zero.
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= mduPkg::divCountT'(mduPkg::DivSteps);
        end else if (stepEnable && count != '0) begin
            count <= count - 1'b1;
        end
    end

    // the step that sees one left is the final one.
    assign lastStep = stepEnable && (count == mduPkg::divCountT'(1));

endmodule

/* source/mduPkg.sv */
package mduPkg;

    // ####################
    // widths and latencies
    // ####################

    localparam int DataWidth   = 32;
    localparam int PhysRegBits = 6;
    localparam int RobIdBits   = 5;

    // register stages between the multiply strobe and a valid result.
    localparam int MulLatency  = 3;

    // one quotient bit is produced per divider iteration.
    localparam int DivSteps     = 32;
    localparam int DivCountBits = $clog2(DivSteps + 1);

    typedef logic [DivCountBits-1:0] divCountT;

    typedef enum logic [1:0] {
        opMult,
        opMultu,
        opDiv,
        opDivu
    } mduOpT;

    // ####################
    // bundles
    // ####################

    // one issued operation with its destinations for both halves.
    typedef struct packed {
        logic                   valid;
        mduOpT                  op;
        logic [PhysRegBits-1:0] rdHi;
        logic [PhysRegBits-1:0] rdLo;
        logic [RobIdBits-1:0]   robIdHi;
        logic [RobIdBits-1:0]   robIdLo;
        logic [DataWidth-1:0]   rs0;
        logic [DataWidth-1:0]   rs1;
    } mduIssueT;

    // the part of an operation that rides along with the arithmetic.
    typedef struct packed {
        logic                   valid;
        logic [PhysRegBits-1:0] rdHi;
        logic [PhysRegBits-1:0] rdLo;
        logic [RobIdBits-1:0]   robIdHi;
        logic [RobIdBits-1:0]   robIdLo;
        logic                   signedOp;
    } mduTagT;

    typedef struct packed {
        logic                   wen;
        logic [PhysRegBits-1:0] rd;
        logic [DataWidth-1:0]   wdata;
    } wbPortT;

    typedef struct packed {
        logic                 setFinish;
        logic [RobIdBits-1:0] id;
    } robFinishT;

endpackage

/* source/mduSequencer.sv */
`timescale 1ns/1ps

module mduSequencer (
    input  logic                           clk,
    input  logic                           rst,
    input  mduPkg::mduIssueT               issue,
    input  mduPkg::mduTagT                 mulOut,
    input  logic [2*mduPkg::DataWidth-1:0] product,
    input  logic                           mulPending,
    input  logic                           divDone,
    input  mduPkg::mduTagT                 divOut,
    input  logic [mduPkg::DataWidth-1:0]   quotient,
    input  logic [mduPkg::DataWidth-1:0]   remainder,
    output logic                           issueReady,
    output logic                           mulStart,
    output logic                           divStart,
    output mduPkg::mduTagT                 tagOut,
    output logic                           divTaken,
    output mduPkg::wbPortT                 wb,
    output mduPkg::robFinishT              robFinish
);
    typedef enum logic [2:0] {
        idle,
        mulHi,
        mulLo,
        divHi,
        divLo
    } seqStateT;

    seqStateT                     state;
    seqStateT                     nextState;
    logic                         mulLast;
    logic                         divActive;
    logic                         accept;
    logic                         isMul;
    mduPkg::mduTagT               beatTag;
    logic [mduPkg::DataWidth-1:0] resHi;
    logic [mduPkg::DataWidth-1:0] resLo;

    // ####################
    // issue side
    // ####################

    // a multiply blocks one cycle, a division blocks until its LO beat.
    assign issueReady = !mulLast && !divActive;
    assign accept     = issue.valid && issueReady;
    assign isMul      = (issue.op == mduPkg::opMult) || (issue.op == mduPkg::opMultu);
    assign mulStart   = accept && isMul;
    assign divStart   = accept && !isMul;

    always_comb begin
        tagOut.valid    = accept;
        tagOut.rdHi     = issue.rdHi;
        tagOut.rdLo     = issue.rdLo;
        tagOut.robIdHi  = issue.robIdHi;
        tagOut.robIdLo  = issue.robIdLo;
        tagOut.signedOp = (issue.op == mduPkg::opMult) || (issue.op == mduPkg::opDiv);
    end

    // ####################
    // write-back FSM
    // ####################

    // a finished multiply always wins; a held division waits until no product is coming.
    always_comb begin
        case (state)
            mulHi: nextState = mulLo;
            divHi: nextState = divLo;
            default: begin
                if (mulOut.valid) begin
                    nextState = mulHi;
                end else if (divDone && state != divLo && !mulPending && !mulStart) begin
                    nextState = divHi;
                end else begin
                    nextState = idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            mulLast   <= 1'b0;
            divActive <= 1'b0;
        end else begin
            state   <= nextState;
            mulLast <= mulStart;
            if (divStart) begin
                divActive <= 1'b1;
            end else if (divTaken) begin
                divActive <= 1'b0;
            end
        end
    end

    // the multiplier moves on every cycle, so both halves are captured here.
    always_ff @(posedge clk) begin
        if (nextState == mulHi) begin
            beatTag <= mulOut;
            resHi   <= product[2*mduPkg::DataWidth-1:mduPkg::DataWidth];
            resLo   <= product[mduPkg::DataWidth-1:0];
        end else if (nextState == divHi) begin
            beatTag <= divOut;
            resHi   <= remainder;
            resLo   <= quotient;
        end
    end

    assign divTaken = (state == divLo);

    always_comb begin
        wb        = '0;
        robFinish = '0;
        case (state)
            mulHi, divHi: begin
                wb.wen              = 1'b1;
                wb.rd               = beatTag.rdHi;
                wb.wdata            = resHi;
                robFinish.setFinish = 1'b1;
                robFinish.id        = beatTag.robIdHi;
            end
            mulLo, divLo: begin
                wb.wen              = 1'b1;
                wb.rd               = beatTag.rdLo;
                wb.wdata            = resLo;
                robFinish.setFinish = 1'b1;
                robFinish.id        = beatTag.robIdLo;
            end
            default: begin
                wb        = '0;
                robFinish = '0;
            end
        endcase
    end

endmodule

/* source/mduTop.sv */
`timescale 1ns/1ps

module mduTop (
    input  logic              clk,
    input  logic              rst,
    input  mduPkg::mduIssueT  issue,
    output logic              issueReady,
    output mduPkg::wbPortT    wb,
    output mduPkg::robFinishT robFinish
);
    logic                           mulStart;
    logic                           divStart;
    logic                           divTaken;
    logic                           mulPending;
    logic                           divDone;
    logic                           stepEnable;
    logic                           load;
    logic                           lastStep;
    mduPkg::mduTagT                 tagOut;
    mduPkg::mduTagT                 mulOut;
    mduPkg::mduTagT                 divOut;
    logic [2*mduPkg::DataWidth-1:0] product;
    logic [mduPkg::DataWidth-1:0]   quotient;
    logic [mduPkg::DataWidth-1:0]   remainder;

    mduSequencer i_mduSequencer (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .mulOut     (mulOut),
        .product    (product),
        .mulPending (mulPending),
        .divDone    (divDone),
        .divOut     (divOut),
        .quotient   (quotient),
        .remainder  (remainder),
        .issueReady (issueReady),
        .mulStart   (mulStart),
        .divStart   (divStart),
        .tagOut     (tagOut),
        .divTaken   (divTaken),
        .wb         (wb),
        .robFinish  (robFinish)
    );

    mulPipeline i_mulPipeline (
        .clk        (clk),
        .rst        (rst),
        .mulStart   (mulStart),
        .a          (issue.rs0),
        .b          (issue.rs1),
        .tagIn      (tagOut),
        .mulOut     (mulOut),
        .product    (product),
        .mulPending (mulPending)
    );

    divDatapath i_divDatapath (
        .clk        (clk),
        .rst        (rst),
        .divStart   (divStart),
        .dividend   (issue.rs0),
        .divisor    (issue.rs1),
        .tagIn      (tagOut),
        .lastStep   (lastStep),
        .divTaken   (divTaken),
        .stepEnable (stepEnable),
        .load       (load),
        .divDone    (divDone),
        .divOut     (divOut),
        .quotient   (quotient),
        .remainder  (remainder)
    );

    divStepCounter i_divStepCounter (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .stepEnable (stepEnable),
        .lastStep   (lastStep)
    );

endmodule

/* source/mulPipeline.sv */
`timescale 1ns/1ps

module mulPipeline (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             mulStart,
    input  logic [mduPkg::DataWidth-1:0]     a,
    input  logic [mduPkg::DataWidth-1:0]     b,
    input  mduPkg::mduTagT                   tagIn,
    output mduPkg::mduTagT                   mulOut,
    output logic [2*mduPkg::DataWidth-1:0]   product,
    output logic                             mulPending
);
    logic [mduPkg::DataWidth-1:0]   magA;
    logic [mduPkg::DataWidth-1:0]   magB;
    logic [2*mduPkg::DataWidth-1:0] magProduct;
    logic                           negate;
    mduPkg::mduTagT                 stageTag;

    mduPkg::mduTagT                 tagPipe  [mduPkg::MulLatency];
    logic [2*mduPkg::DataWidth-1:0] prodPipe [mduPkg::MulLatency];
    logic                           negPipe  [mduPkg::MulLatency];

    // signed operands are multiplied as magnitudes, the sign is restored at the end.
    always_comb begin
        magA = (tagIn.signedOp && a[mduPkg::DataWidth-1]) ? -a : a;
        magB = (tagIn.signedOp && b[mduPkg::DataWidth-1]) ? -b : b;
        negate = tagIn.signedOp && (a[mduPkg::DataWidth-1] ^ b[mduPkg::DataWidth-1]);
        magProduct = {{mduPkg::DataWidth{1'b0}}, magA} * {{mduPkg::DataWidth{1'b0}}, magB};
        stageTag = tagIn;
        stageTag.valid = mulStart && tagIn.valid;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mduPkg::MulLatency; i++) begin
                tagPipe[i] <= '0;
            end
        end else begin
            tagPipe[0] <= stageTag;
            for (int i = 1; i < mduPkg::MulLatency; i++) begin
                tagPipe[i] <= tagPipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        prodPipe[0] <= magProduct;
        negPipe[0]  <= negate;
        for (int i = 1; i < mduPkg::MulLatency; i++) begin
            prodPipe[i] <= prodPipe[i-1];
            negPipe[i]  <= negPipe[i-1];
        end
    end

    assign mulOut  = tagPipe[mduPkg::MulLatency-1];
    assign product = negPipe[mduPkg::MulLatency-1] ? -prodPipe[mduPkg::MulLatency-1]
                                                   : prodPipe[mduPkg::MulLatency-1];

    always_comb begin
        mulPending = 1'b0;
        for (int i = 0; i < mduPkg::MulLatency; i++) begin
            mulPending = mulPending | tagPipe[i].valid;
        end
    end

endmodule
